//--- source/rename_cfg.svh
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// architectural register number width
`define REG_SEL 5

// rename tag width and entry count
`define RRF_SEL 4
`define RRF_NUM 16

// datapath width
`define DATA_LEN 32

// execution unit result ports into the rename file
`define WB_PORTS 2

`endif

//--- source/rename_pkg.sv
`default_nettype none
`include "rename_cfg.svh"

package rename_pkg;

    typedef struct packed {
        logic [`REG_SEL-1:0] rs1;
        logic [`REG_SEL-1:0] rs2;
        logic [`REG_SEL-1:0] rd;
        logic                dst_en;
        logic                src1_zero;  // operand is x0 or unused
        logic                src2_zero;
        logic                valid;
    } rename_req_t;

    typedef struct packed {
        logic [`DATA_LEN-`RRF_SEL-1:0] rsvd;
        logic [`RRF_SEL-1:0]           tag;
    } src_pend_t;

    // one operand word, read as value or as pending tag
    typedef union packed {
        logic [`DATA_LEN-1:0] data;
        src_pend_t            pend;
    } src_opr_u;

    typedef struct packed {
        src_opr_u opr;
        logic     ready;  // selects opr.data when set and opr.pend.tag when clear
    } src_opr_t;

    typedef struct packed {
        logic                 we;
        logic [`RRF_SEL-1:0]  tag;
        logic [`DATA_LEN-1:0] data;
    } wb_t;

    typedef struct packed {
        logic [1:0]          com_num;  // entries retired this cycle
        logic                we;
        logic [`REG_SEL-1:0] rd;
        logic [`RRF_SEL-1:0] tag;
    } commit_t;

    typedef struct packed {
        logic [`REG_SEL-1:0] rd;
        logic [`RRF_SEL-1:0] tag;
        logic                en;
    } dst_info_t;

endpackage

`default_nettype wire

//--- source/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

    typedef enum logic [2:0] {
        NONE   = 3'd0,
        ALU    = 3'd1,
        BRANCH = 3'd2,
        MUL    = 3'd3,
        LDST   = 3'd4
    } rs_type_e;

    typedef struct packed {
        logic       req1;  // slot 1 targets this station
        logic       req2;
        logic [1:0] num;
    } rs_station_req_t;

    typedef struct packed {
        rs_station_req_t alu;
        rs_station_req_t branch;
        rs_station_req_t mul;
        rs_station_req_t ldst;
    } rs_req_t;

endpackage

`default_nettype wire

//--- source/arch_reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "rename_cfg.svh"

module arch_reg_file (
    input  wire                     clk_i,
    input  wire                     reset_i,
    input  wire [`REG_SEL-1:0]      rs1_i,
    input  wire [`REG_SEL-1:0]      rs2_i,
    input  wire [`REG_SEL-1:0]      rd_i,
    input  wire                     dst_en_i,
    input  wire [`RRF_SEL-1:0]      alloc_tag_i,
    input  rename_pkg::commit_t     commit_i,
    input  wire [`DATA_LEN-1:0]     commit_data_i,
    output logic [`DATA_LEN-1:0]    rs1_data_o,
    output logic [`DATA_LEN-1:0]    rs2_data_o,
    output logic                    rs1_busy_o,
    output logic                    rs2_busy_o,
    output logic [`RRF_SEL-1:0]     rs1_tag_o,
    output logic [`RRF_SEL-1:0]     rs2_tag_o
);

    localparam int REG_NUM = 1 << `REG_SEL;

    logic [`DATA_LEN-1:0] data_q [REG_NUM];
    logic [`RRF_SEL-1:0]  tag_q  [REG_NUM];
    logic [REG_NUM-1:0]   busy_q;

    logic commit_wr;
    logic busy_set;

    assign commit_wr = commit_i.we && (commit_i.rd != '0);  // x0 stays zero
    assign busy_set  = dst_en_i && (rd_i != '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                data_q[i] <= '0;
                tag_q[i]  <= '0;
            end
            busy_q <= '0;
        end else begin
            if (commit_wr) begin
                data_q[commit_i.rd] <= commit_data_i;
                // only the youngest mapping releases the register
                if (tag_q[commit_i.rd] == commit_i.tag) begin
                    busy_q[commit_i.rd] <= 1'b0;
                end
            end
            if (busy_set) begin  // later assignment wins over commit
                busy_q[rd_i] <= 1'b1;
                tag_q[rd_i]  <= alloc_tag_i;
            end
        end
    end

    assign rs1_data_o = data_q[rs1_i];
    assign rs2_data_o = data_q[rs2_i];
    assign rs1_busy_o = busy_q[rs1_i];
    assign rs2_busy_o = busy_q[rs2_i];
    assign rs1_tag_o  = tag_q[rs1_i];
    assign rs2_tag_o  = tag_q[rs2_i];

endmodule

`default_nettype wire

//--- source/rename_reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "rename_cfg.svh"

module rename_reg_file (
    input  wire                                 clk_i,
    input  wire                                 reset_i,
    input  wire [`RRF_SEL-1:0]                  rs1_tag_i,
    input  wire [`RRF_SEL-1:0]                  rs2_tag_i,
    output logic [`DATA_LEN-1:0]                rs1_data_o,
    output logic [`DATA_LEN-1:0]                rs2_data_o,
    output logic                                rs1_valid_o,
    output logic                                rs2_valid_o,
    input  rename_pkg::wb_t [`WB_PORTS-1:0]     wb_i,
    input  wire                                 alloc_en_i,
    input  wire [`RRF_SEL-1:0]                  alloc_tag_i,
    input  wire [`RRF_SEL-1:0]                  commit_tag_i,
    output logic [`DATA_LEN-1:0]                commit_data_o
);

    logic [`DATA_LEN-1:0] data_q [`RRF_NUM];
    logic [`RRF_NUM-1:0]  valid_q;

    // result payload
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < `WB_PORTS; p++) begin
            if (wb_i[p].we) begin
                data_q[wb_i[p].tag] <= wb_i[p].data;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            for (int p = 0; p < `WB_PORTS; p++) begin
                if (wb_i[p].we) begin
                    valid_q[wb_i[p].tag] <= 1'b1;
                end
            end
            // a fresh allocation overrides a stale writeback
            if (alloc_en_i) begin
                valid_q[alloc_tag_i] <= 1'b0;
            end
        end
    end

    assign rs1_data_o  = data_q[rs1_tag_i];
    assign rs2_data_o  = data_q[rs2_tag_i];
    assign rs1_valid_o = valid_q[rs1_tag_i];
    assign rs2_valid_o = valid_q[rs2_tag_i];

    assign commit_data_o = data_q[commit_tag_i];  // copied into the arf on commit

endmodule

`default_nettype wire

//--- source/rrf_allocator.sv
`timescale 1ns/1ps
`default_nettype none
`include "rename_cfg.svh"

module rrf_allocator (
    input  wire                     clk_i,
    input  wire                     reset_i,
    input  wire                     req_en_i,
    input  wire                     stall_i,
    input  wire [1:0]               com_num_i,
    output logic                    alloc_en_o,
    output logic [`RRF_SEL-1:0]     alloc_tag_o,
    output rename_pkg::dst_info_t   dst_o,
    input  wire [`REG_SEL-1:0]      rd_i,
    output logic                    allocatable_o,
    output logic [`RRF_SEL:0]       freenum_o,
    output logic [`RRF_SEL-1:0]     rrfptr_o,
    output logic                    nextrrfcyc_o
);

    logic [`RRF_SEL-1:0]   ptr_q;
    logic                  cyc_q;
    logic [`RRF_SEL:0]     freenum_q;
    logic                  wrap;
    rename_pkg::dst_info_t dst_q;

    assign allocatable_o = (freenum_q != '0);
    assign alloc_en_o    = req_en_i && !stall_i && allocatable_o;
    assign wrap          = (ptr_q == (`RRF_SEL)'(`RRF_NUM - 1));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ptr_q     <= '0;
            cyc_q     <= 1'b0;
            freenum_q <= (`RRF_SEL+1)'(`RRF_NUM);
            dst_q     <= '0;
        end else begin
            if (alloc_en_o) begin
                ptr_q <= wrap ? '0 : ptr_q + 1'b1;
                cyc_q <= cyc_q ^ wrap;  // flips each lap around the file
            end
            freenum_q <= freenum_q - (`RRF_SEL+1)'(alloc_en_o) + (`RRF_SEL+1)'(com_num_i);
            dst_q.rd  <= rd_i;
            dst_q.tag <= ptr_q;
            dst_q.en  <= alloc_en_o;
        end
    end

    assign alloc_tag_o  = ptr_q;
    assign dst_o        = dst_q;
    assign freenum_o    = freenum_q;
    assign rrfptr_o     = ptr_q;
    assign nextrrfcyc_o = cyc_q;

endmodule

`default_nettype wire

//--- source/src_opr_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rename_cfg.svh"

module src_opr_stage (
    input  wire                     clk_i,
    input  wire                     reset_i,
    input  wire                     zero_i,
    input  wire                     arf_busy_i,
    input  wire [`DATA_LEN-1:0]     arf_data_i,
    input  wire [`RRF_SEL-1:0]      arf_tag_i,
    input  wire                     rrf_valid_i,
    input  wire [`DATA_LEN-1:0]     rrf_data_i,
    output rename_pkg::src_opr_t    src_o
);

    rename_pkg::src_opr_t src_d;
    rename_pkg::src_opr_t src_q;

    always_comb begin
        src_d = '0;
        if (zero_i) begin
            src_d.ready = 1'b1;  // x0 or no operand
        end else if (!arf_busy_i) begin
            src_d.opr.data = arf_data_i;
            src_d.ready    = 1'b1;
        end else if (rrf_valid_i) begin
            src_d.opr.data = rrf_data_i;  // produced but not yet committed
            src_d.ready    = 1'b1;
        end else begin
            src_d.opr.pend.tag = arf_tag_i;  // wait on this tag
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            src_q <= '0;
        end else begin
            src_q <= src_d;
        end
    end

    assign src_o = src_q;

endmodule

`default_nettype wire

//--- source/rs_request_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rs_request_gen (
    input  wire                             clk_i,
    input  wire                             reset_i,
    input  dispatch_pkg::rs_type_e [1:0]    inst_type_i,
    output dispatch_pkg::rs_req_t           rs_req_o
);

    dispatch_pkg::rs_req_t req_d;
    dispatch_pkg::rs_req_t req_q;

    function automatic dispatch_pkg::rs_station_req_t station_req(
        input dispatch_pkg::rs_type_e t1,
        input dispatch_pkg::rs_type_e t2,
        input dispatch_pkg::rs_type_e st
    );
        dispatch_pkg::rs_station_req_t r;
        r.req1 = (t1 == st);
        r.req2 = (t2 == st);
        r.num  = {1'b0, r.req1} + {1'b0, r.req2};  // 0, 1 or 2 entries wanted
        return r;
    endfunction

    always_comb begin
        req_d.alu    = station_req(inst_type_i[0], inst_type_i[1], dispatch_pkg::ALU);
        req_d.branch = station_req(inst_type_i[0], inst_type_i[1], dispatch_pkg::BRANCH);
        req_d.mul    = station_req(inst_type_i[0], inst_type_i[1], dispatch_pkg::MUL);
        req_d.ldst   = station_req(inst_type_i[0], inst_type_i[1], dispatch_pkg::LDST);
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req_q <= '0;
        end else begin
            req_q <= req_d;
        end
    end

    assign rs_req_o = req_q;

endmodule

`default_nettype wire

//--- source/rename_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rename_cfg.svh"

module rename_unit (
    input  wire                                 clk_i,
    input  wire                                 reset_i,
    input  rename_pkg::rename_req_t             rename_req_i,
    input  dispatch_pkg::rs_type_e [1:0]        inst_type_i,
    input  wire                                 stall_i,
    input  rename_pkg::wb_t [`WB_PORTS-1:0]     wb_i,
    input  rename_pkg::commit_t                 commit_i,
    output rename_pkg::src_opr_t                src1_o,
    output rename_pkg::src_opr_t                src2_o,
    output rename_pkg::dst_info_t               dst_o,
    output dispatch_pkg::rs_req_t               rs_req_o,
    output logic                                allocatable_o,
    output logic [`RRF_SEL:0]                   freenum_o,
    output logic [`RRF_SEL-1:0]                 rrfptr_o,
    output logic                                nextrrfcyc_o
);

    logic                 req_en;
    logic                 alloc_en;
    logic [`RRF_SEL-1:0]  alloc_tag;
    logic [`DATA_LEN-1:0] rs1_arf_data, rs2_arf_data;
    logic                 rs1_busy, rs2_busy;
    logic [`RRF_SEL-1:0]  rs1_tag, rs2_tag;
    logic [`DATA_LEN-1:0] rs1_rrf_data, rs2_rrf_data;
    logic                 rs1_rrf_valid, rs2_rrf_valid;
    logic [`DATA_LEN-1:0] commit_data;

    assign req_en = rename_req_i.valid && rename_req_i.dst_en;

    rrf_allocator u_alloc (
        .clk_i(clk_i), .reset_i(reset_i),
        .req_en_i(req_en), .stall_i(stall_i), .com_num_i(commit_i.com_num),
        .alloc_en_o(alloc_en), .alloc_tag_o(alloc_tag), .dst_o(dst_o),
        .rd_i(rename_req_i.rd), .allocatable_o(allocatable_o), .freenum_o(freenum_o),
        .rrfptr_o(rrfptr_o), .nextrrfcyc_o(nextrrfcyc_o)
    );

    arch_reg_file u_arf (
        .clk_i(clk_i), .reset_i(reset_i),
        .rs1_i(rename_req_i.rs1), .rs2_i(rename_req_i.rs2),
        .rd_i(rename_req_i.rd), .dst_en_i(alloc_en), .alloc_tag_i(alloc_tag),
        .commit_i(commit_i), .commit_data_i(commit_data),
        .rs1_data_o(rs1_arf_data), .rs2_data_o(rs2_arf_data),
        .rs1_busy_o(rs1_busy), .rs2_busy_o(rs2_busy),
        .rs1_tag_o(rs1_tag), .rs2_tag_o(rs2_tag)
    );

    rename_reg_file u_rrf (
        .clk_i(clk_i), .reset_i(reset_i),
        .rs1_tag_i(rs1_tag), .rs2_tag_i(rs2_tag),
        .rs1_data_o(rs1_rrf_data), .rs2_data_o(rs2_rrf_data),
        .rs1_valid_o(rs1_rrf_valid), .rs2_valid_o(rs2_rrf_valid),
        .wb_i(wb_i), .alloc_en_i(alloc_en), .alloc_tag_i(alloc_tag),
        .commit_tag_i(commit_i.tag), .commit_data_o(commit_data)
    );

    src_opr_stage u_src1 (
        .clk_i(clk_i), .reset_i(reset_i), .zero_i(rename_req_i.src1_zero),
        .arf_busy_i(rs1_busy), .arf_data_i(rs1_arf_data), .arf_tag_i(rs1_tag),
        .rrf_valid_i(rs1_rrf_valid), .rrf_data_i(rs1_rrf_data), .src_o(src1_o)
    );

    src_opr_stage u_src2 (
        .clk_i(clk_i), .reset_i(reset_i), .zero_i(rename_req_i.src2_zero),
        .arf_busy_i(rs2_busy), .arf_data_i(rs2_arf_data), .arf_tag_i(rs2_tag),
        .rrf_valid_i(rs2_rrf_valid), .rrf_data_i(rs2_rrf_data), .src_o(src2_o)
    );

    rs_request_gen u_rs_req (
        .clk_i(clk_i), .reset_i(reset_i),
        .inst_type_i(inst_type_i), .rs_req_o(rs_req_o)
    );

endmodule

`default_nettype wire

//--- tb/rename_unit_props.sv
`timescale 1ns/1ps
`default_nettype none
`include "rename_cfg.svh"

module rename_unit_props (
    input  wire                     clk_i,
    input  wire                     reset_i,
    input  wire                     stall_i,
    input  rename_pkg::dst_info_t   dst_o,
    input  wire                     allocatable_o,
    input  wire [`RRF_SEL:0]        freenum_o
);

    allocatable_matches_free: assert property (
        @(posedge clk_i) disable iff (reset_i)
        allocatable_o == (freenum_o != '0)
    ) else $error("allocatable_o is %b with freenum_o %0d", allocatable_o, freenum_o);

    // dst_o is registered, so a stall shows up one edge later
    no_dst_after_stall: assert property (
        @(posedge clk_i) disable iff (reset_i)
        $past(stall_i) |-> !dst_o.en
    ) else $error("dst_o.en set in the cycle after stall_i");

    free_count_bounded: assert property (
        @(posedge clk_i) disable iff (reset_i)
        freenum_o <= (`RRF_SEL+1)'(`RRF_NUM)
    ) else $error("freenum_o %0d above the entry count", freenum_o);

endmodule

`default_nettype wire

//--- tb/rename_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "rename_cfg.svh"

module rename_unit_tb;

    logic clk_i = 1'b0;
    logic reset_i;
    rename_pkg::rename_req_t             rename_req;
    dispatch_pkg::rs_type_e [1:0]        inst_type;
    logic                                stall;
    rename_pkg::wb_t [`WB_PORTS-1:0]     wb;
    rename_pkg::commit_t                 commit;
    rename_pkg::src_opr_t                src1_o, src2_o;
    rename_pkg::dst_info_t               dst_o;
    dispatch_pkg::rs_req_t               rs_req_o;
    logic                                allocatable_o, nextrrfcyc_o;
    logic [`RRF_SEL:0]                   freenum_o;
    logic [`RRF_SEL-1:0]                 rrfptr_o;

    // shadow of register state
    logic [`DATA_LEN-1:0] m_data [32];
    logic [`RRF_SEL-1:0]  m_tag [32];
    logic [31:0]          m_busy;
    logic [`DATA_LEN-1:0] m_rdata [`RRF_NUM];
    logic [`RRF_NUM-1:0]  m_valid;
    logic [`RRF_SEL-1:0]  m_ptr;
    logic                 m_cyc;
    int m_free;
    int seed = 96;
    int err_src = 0, err_dst = 0, err_req = 0, err_state = 0, err_other = 0;

    always #20 clk_i = ~clk_i;

    rename_unit u_dut (
        .clk_i(clk_i), .reset_i(reset_i), .rename_req_i(rename_req),
        .inst_type_i(inst_type), .stall_i(stall), .wb_i(wb), .commit_i(commit),
        .src1_o(src1_o), .src2_o(src2_o), .dst_o(dst_o), .rs_req_o(rs_req_o),
        .allocatable_o(allocatable_o), .freenum_o(freenum_o),
        .rrfptr_o(rrfptr_o), .nextrrfcyc_o(nextrrfcyc_o)
    );

    bind rename_unit rename_unit_props u_props (
        .clk_i(clk_i), .reset_i(reset_i), .stall_i(stall_i), .dst_o(dst_o),
        .allocatable_o(allocatable_o), .freenum_o(freenum_o)
    );

    task automatic check_src(input string name, input rename_pkg::src_opr_t got,
                             input rename_pkg::src_opr_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
            err_src++;
        end
    endtask

    task automatic check_dst(input string name, input rename_pkg::dst_info_t got,
                             input rename_pkg::dst_info_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
            err_dst++;
        end
    endtask

    task automatic check_req(input string name, input dispatch_pkg::rs_req_t got,
                             input dispatch_pkg::rs_req_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
            err_req++;
        end
    endtask

    task automatic check_state(input string name, input logic [`RRF_SEL:0] got,
                               input logic [`RRF_SEL:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %0d exp %0d", $time, name, got, exp);
            err_state++;
        end
    endtask

    function automatic rename_pkg::src_opr_t expect_src(input logic [`REG_SEL-1:0] r,
                                                        input logic zero);
        rename_pkg::src_opr_t e;
        e = '0;
        if (zero) begin
            e.ready = 1'b1;
        end else if (!m_busy[r]) begin
            e.ready    = 1'b1;
            e.opr.data = m_data[r];
        end else if (m_valid[m_tag[r]]) begin
            e.ready    = 1'b1;
            e.opr.data = m_rdata[m_tag[r]];
        end else begin
            e.opr.pend.tag = m_tag[r];
        end
        return e;
    endfunction

    function automatic dispatch_pkg::rs_station_req_t mark_slot(
        input dispatch_pkg::rs_station_req_t st, input int slot);
        dispatch_pkg::rs_station_req_t m;
        m = st;
        if (slot == 0) m.req1 = 1'b1;
        else m.req2 = 1'b1;
        m.num = m.num + 2'd1;
        return m;
    endfunction

    function automatic dispatch_pkg::rs_req_t expected_req(input dispatch_pkg::rs_type_e [1:0] t);
        dispatch_pkg::rs_req_t r;
        r = '0;
        for (int s = 0; s < 2; s++) begin
            case (t[s])
                dispatch_pkg::ALU:    r.alu    = mark_slot(r.alu, s);
                dispatch_pkg::BRANCH: r.branch = mark_slot(r.branch, s);
                dispatch_pkg::MUL:    r.mul    = mark_slot(r.mul, s);
                dispatch_pkg::LDST:   r.ldst   = mark_slot(r.ldst, s);
                default: ;
            endcase
        end
        return r;
    endfunction

    task automatic set_req(input logic [`REG_SEL-1:0] rs1, input logic [`REG_SEL-1:0] rs2,
                           input logic [`REG_SEL-1:0] rd, input logic dst_en,
                           input logic z1, input logic z2);
        rename_req = '{rs1: rs1, rs2: rs2, rd: rd, dst_en: dst_en,
                       src1_zero: z1, src2_zero: z2, valid: 1'b1};
    endtask

    // predict from pre-edge state and update the model before comparing after the edge
    task automatic run_cycle();
        rename_pkg::src_opr_t  e1, e2;
        rename_pkg::dst_info_t ed;
        dispatch_pkg::rs_req_t er;
        logic alloc;
        e1 = expect_src(rename_req.rs1, rename_req.src1_zero);
        e2 = expect_src(rename_req.rs2, rename_req.src2_zero);
        er = expected_req(inst_type);
        alloc = rename_req.valid && rename_req.dst_en && !stall && (m_free > 0);
        ed = '{rd: rename_req.rd, tag: m_ptr, en: alloc};
        if (commit.we && commit.rd != '0) begin
            m_data[commit.rd] = m_rdata[commit.tag];
            if (m_tag[commit.rd] == commit.tag) m_busy[commit.rd] = 1'b0;
        end
        if (alloc && rename_req.rd != '0) begin
            m_busy[rename_req.rd] = 1'b1;
            m_tag[rename_req.rd]  = m_ptr;
        end
        for (int p = 0; p < `WB_PORTS; p++) begin
            if (wb[p].we) begin
                m_valid[wb[p].tag] = 1'b1;
                m_rdata[wb[p].tag] = wb[p].data;
            end
        end
        if (alloc) begin
            m_valid[m_ptr] = 1'b0;
            m_ptr = m_ptr + 1'b1;
            if (m_ptr == '0) m_cyc = ~m_cyc;  // new lap
        end
        m_free = m_free - int'(alloc) + int'(commit.com_num);
        @(negedge clk_i);
        check_src("src1_o", src1_o, e1);
        check_src("src2_o", src2_o, e2);
        check_dst("dst_o", dst_o, ed);
        check_req("rs_req_o", rs_req_o, er);
        check_state("freenum_o", freenum_o, (`RRF_SEL+1)'(m_free));
        check_state("allocatable_o", (`RRF_SEL+1)'(allocatable_o), (`RRF_SEL+1)'(m_free > 0));
        check_state("rrfptr_o", {1'b0, rrfptr_o}, {1'b0, m_ptr});
        check_state("nextrrfcyc_o", (`RRF_SEL+1)'(nextrrfcyc_o), (`RRF_SEL+1)'(m_cyc));
        rename_req = '0;
        wb = '0;
        commit = '0;
    endtask

    task automatic reset_dut();
        int n;
        reset_i = 1'b1;
        for (int i = 0; i < 32; i++) begin
            m_data[i] = '0;
            m_tag[i]  = '0;
        end
        m_busy  = '0;
        m_valid = '0;
        m_ptr   = '0;
        m_cyc   = 1'b0;
        m_free  = `RRF_NUM;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        n = 0;
        while (!allocatable_o && n < 10) begin
            @(negedge clk_i);
            n++;
        end
        if (!allocatable_o) begin
            $display("timeout: allocatable_o never rose after reset");
            err_other++;
        end
        check_dst("dst_o", dst_o, '0);
        check_req("rs_req_o", rs_req_o, '0);
    endtask

    task automatic reset_reads();
        for (int i = 0; i < 8; i++) begin
            set_req(5'($random(seed)), 5'($random(seed)), 5'd0, 1'b0, 1'b0, 1'b0);
            run_cycle();
        end
        set_req(5'd0, 5'd0, 5'd5, 1'b1, 1'b0, 1'b0);
        run_cycle();
        set_req(5'd5, 5'd5, 5'd0, 1'b0, 1'b1, 1'b0);  // zero flag overrides the busy x5
        run_cycle();
    endtask

    task automatic rename_sequence();
        for (int r = 1; r <= 4; r++) begin
            set_req(5'd0, 5'd0, 5'(r), 1'b1, 1'b0, 1'b0);
            run_cycle();
        end
        for (int r = 1; r <= 4; r++) begin
            set_req(5'(r), 5'(5 - r), 5'd0, 1'b0, 1'b0, 1'b0);
            run_cycle();
        end
    endtask

    task automatic writeback_ports();
        wb[0] = '{we: 1'b1, tag: m_tag[1], data: $random(seed)};
        wb[1] = '{we: 1'b1, tag: m_tag[2], data: $random(seed)};
        run_cycle();
        set_req(5'd1, 5'd2, 5'd0, 1'b0, 1'b0, 1'b0);
        run_cycle();
    endtask

    task automatic fill_and_drain();
        int n;
        n = 0;
        while (allocatable_o && n < 2 * `RRF_NUM) begin
            set_req(5'd0, 5'd0, 5'(n % 31 + 1), 1'b1, 1'b0, 1'b0);
            run_cycle();
            n++;
        end
        if (allocatable_o) begin
            $display("timeout: allocatable_o stayed high after %0d renames", n);
            err_other++;
        end
        set_req(5'd0, 5'd0, 5'd9, 1'b1, 1'b0, 1'b0);  // refused while the file is full
        run_cycle();
        for (int i = 0; i < `RRF_NUM / 2; i++) begin
            commit.com_num = 2'd2;
            run_cycle();
        end
        set_req(5'd0, 5'd0, 5'd9, 1'b1, 1'b0, 1'b0);
        run_cycle();
    endtask

    task automatic commit_copy();
        logic [`RRF_SEL-1:0] t1, t2;
        t1 = m_ptr;
        set_req(5'd0, 5'd0, 5'd7, 1'b1, 1'b0, 1'b0);
        run_cycle();
        wb[0] = '{we: 1'b1, tag: t1, data: $random(seed)};
        run_cycle();
        commit = '{com_num: 2'd1, we: 1'b1, rd: 5'd7, tag: t1};
        wb[0] = '{we: 1'b1, tag: t1, data: ~m_rdata[t1]};  // x7 must now read from the arf
        run_cycle();
        set_req(5'd7, 5'd7, 5'd0, 1'b0, 1'b0, 1'b0);
        run_cycle();
        t2 = m_ptr;
        set_req(5'd0, 5'd0, 5'd8, 1'b1, 1'b0, 1'b0);
        run_cycle();
        wb[1] = '{we: 1'b1, tag: t2, data: $random(seed)};
        run_cycle();
        set_req(5'd0, 5'd0, 5'd8, 1'b1, 1'b0, 1'b0);  // x8 renamed again before commit
        run_cycle();
        commit = '{com_num: 2'd1, we: 1'b1, rd: 5'd8, tag: t2};
        run_cycle();
        set_req(5'd8, 5'd8, 5'd0, 1'b0, 1'b0, 1'b0);
        run_cycle();
    endtask

    task automatic type_pairs();
        for (int i = 0; i < 12; i++) begin
            inst_type[0] = dispatch_pkg::rs_type_e'(3'($unsigned($random(seed)) % 5));
            inst_type[1] = dispatch_pkg::rs_type_e'(3'($unsigned($random(seed)) % 5));
            stall = 1'($random(seed));
            set_req(5'(i), 5'(i + 1), 5'(i + 9), 1'b1, 1'b0, 1'b0);
            run_cycle();
        end
        stall = 1'b0;
    endtask

    initial begin
        reset_i      = 1'b1;
        rename_req   = '0;
        inst_type[0] = dispatch_pkg::NONE;
        inst_type[1] = dispatch_pkg::NONE;
        stall        = 1'b0;
        wb           = '0;
        commit       = '0;
        reset_dut();
        reset_reads();
        rename_sequence();
        writeback_ports();
        fill_and_drain();
        commit_copy();
        type_pairs();
        $display("errors: src %0d, dst %0d, req %0d, state %0d, other %0d",
                 err_src, err_dst, err_req, err_state, err_other);
        if (err_src + err_dst + err_req + err_state + err_other == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/rename_pkg.sv
source/dispatch_pkg.sv
source/arch_reg_file.sv
source/rename_reg_file.sv
source/rrf_allocator.sv
source/src_opr_stage.sv
source/rs_request_gen.sv
source/rename_unit.sv
tb/rename_unit_props.sv
tb/rename_unit_tb.sv

//--- Makefile
TOP = rename_unit_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir

.PHONY: sim clean
